//--- source/merge_pkg.sv
package merge_pkg;

    //////////////////////////////////////////////////////////////////////
    // stream constants
    //////////////////////////////////////////////////////////////////////

    // width of every word on the bypass, result and output streams
    localparam int stream_w = 128;

    // each base is packed as two bits, so one word carries 64 bases
    localparam int base_w = 2;
    localparam int bases_per_tx = stream_w / base_w;

    // position widths cover queries up to 1023 and targets up to 4095 bases
    localparam int q_pos_w = 10;
    localparam int t_pos_w = 12;

    // alignment scores are signed
    localparam int score_w = 9;

    //////////////////////////////////////////////////////////////////////
    // word layouts
    //////////////////////////////////////////////////////////////////////

    typedef logic [stream_w-1:0] stream_word_t;

    // query header, the length sits in the low 16 bits and the
    // merger writes the local score just above it
    typedef struct packed {
        logic [stream_w-16-score_w-1:0] pad;
        logic signed [score_w-1:0]      score;
        logic [15:0]                    len;
    } query_header_t;

    // target header, only the length is interpreted here
    typedef struct packed {
        logic [stream_w-16-1:0] rest;
        logic [15:0]            len;
    } target_header_t;

    // one alignment result, fields listed from the top down
    typedef struct packed {
        logic [stream_w-q_pos_w-2*t_pos_w-2*score_w-1:0] pad;
        logic [q_pos_w-1:0]                              q_base_local;
        logic [t_pos_w-1:0]                              t_base_local;
        logic signed [score_w-1:0]                       local_score;
        logic [t_pos_w-1:0]                              t_base_global;
        logic signed [score_w-1:0]                       global_score;
    } smwa_result_t;

    //////////////////////////////////////////////////////////////////////
    // control encodings
    //////////////////////////////////////////////////////////////////////

    typedef enum logic [3:0] {
        wait_result,
        header_q,
        data_q,
        header_t,
        data_t,
        extra,
        trailer_q,
        trailer_t,
        trailer_g
    } merge_state_t;

    typedef enum logic [2:0] {
        sel_pass,
        sel_q_header,
        sel_trailer_q,
        sel_trailer_t,
        sel_trailer_g
    } word_sel_t;

endpackage

//--- source/tx_counter.sv
`timescale 1ns/1ps

// counts the bypass words still owed in the current counted section
module tx_counter import merge_pkg::*; #(
    parameter int num_extra_tx = 3
) (
    input  logic         clk,
    input  logic         rst,
    input  stream_word_t s2i_data,
    input  logic         load_len,
    input  logic         len_is_target,
    input  logic         load_extra,
    input  logic         step,
    output logic         section_empty
);

    localparam int lg_bases = $clog2(bases_per_tx);

    // wide enough for the longest target in words, plus one spare bit
    localparam int cnt_w = t_pos_w - lg_bases + 1;

    query_header_t  q_hdr;
    target_header_t t_hdr;
    logic [t_pos_w-1:0] len;
    logic [t_pos_w:0]   len_round;
    logic [cnt_w-1:0]   count;

    assign q_hdr = query_header_t'(s2i_data);
    assign t_hdr = target_header_t'(s2i_data);

    // the query length field is narrower than the target one
    assign len = len_is_target ? t_hdr.len[t_pos_w-1:0]
                               : {{(t_pos_w-q_pos_w){1'b0}}, q_hdr.len[q_pos_w-1:0]};

    // a partly filled last word still has to be forwarded
    assign len_round = {1'b0, len} + (t_pos_w+1)'(bases_per_tx - 1);

    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else if (load_len) begin
            count <= cnt_w'(len_round >> lg_bases);
        end else if (load_extra) begin
            count <= cnt_w'(num_extra_tx);
        end else if (step) begin
            count <= count - 1'b1;
        end
    end

    assign section_empty = (count == '0);

    // the controller must stop taking words once the section is done
    a_no_underflow: assert property (
        @(posedge clk) disable iff (rst)
        step |-> (count != '0)
    );

endmodule

//--- source/word_builder.sv
`timescale 1ns/1ps

// rewrites the accepted bypass word with result fields and holds it in
// the output register until the sink takes it
module word_builder import merge_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  logic         load,
    input  word_sel_t    sel,
    input  smwa_result_t s1i_data,
    input  stream_word_t s2i_data,
    output logic         s1o_valid,
    input  logic         s1o_rdy,
    output stream_word_t s1o_data,
    output logic         out_free
);

    localparam int half_w = stream_w / 2;

    query_header_t q_hdr_in;
    query_header_t q_hdr_out;
    stream_word_t  next_word;

    assign q_hdr_in = query_header_t'(s2i_data);

    // keep the query length, drop whatever sat above it and put the
    // local score in its own field
    always_comb begin
        q_hdr_out = '0;
        q_hdr_out.len = q_hdr_in.len;
        q_hdr_out.score = s1i_data.local_score;
    end

    //////////////////////////////////////////////////////////////////////
    // next word mux
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        case (sel)
            sel_q_header: begin
                next_word = stream_word_t'(q_hdr_out);
            end
            // local query end base on top of the lower bypass half
            sel_trailer_q: begin
                next_word = {{(half_w-q_pos_w){1'b0}}, s1i_data.q_base_local,
                             s2i_data[half_w-1:0]};
            end
            // this trailer is made only of result fields
            sel_trailer_t: begin
                next_word = {{(half_w-t_pos_w){1'b0}}, s1i_data.t_base_global,
                             {(half_w-t_pos_w){1'b0}}, s1i_data.t_base_local};
            end
            sel_trailer_g: begin
                next_word = {s2i_data[stream_w-1:half_w],
                             {(half_w-score_w){s1i_data.global_score[score_w-1]}},
                             s1i_data.global_score};
            end
            default: begin
                next_word = s2i_data;
            end
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // output register
    //////////////////////////////////////////////////////////////////////

    // room exists when empty or when the held word leaves on this edge
    assign out_free = !s1o_valid || s1o_rdy;

    always_ff @(posedge clk) begin
        if (rst) begin
            s1o_valid <= 1'b0;
        end else if (load) begin
            s1o_valid <= 1'b1;
        end else if (s1o_rdy) begin
            s1o_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            s1o_data <= next_word;
        end
    end

    // a stalled word must not change under the sink
    a_hold_stalled: assert property (
        @(posedge clk) disable iff (rst)
        (s1o_valid && !s1o_rdy) |=> (s1o_valid && $stable(s1o_data))
    );

endmodule

//--- source/merge_ctrl.sv
`timescale 1ns/1ps

// walks one record at a time through its sections and decides when a
// bypass word may be taken and how it is to be rewritten
module merge_ctrl import merge_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      s1i_valid,
    output logic      s1i_rdy,
    input  logic      s2i_valid,
    output logic      s2i_rdy,
    input  logic      out_free,
    input  logic      section_empty,
    output logic      load,
    output word_sel_t sel,
    output logic      load_len,
    output logic      len_is_target,
    output logic      load_extra,
    output logic      step
);

    merge_state_t state;
    merge_state_t state_nxt;

    // high in any state that wants a bypass word this cycle
    logic takes_word;

    // a bypass word moves on this edge
    logic xfer;

    //////////////////////////////////////////////////////////////////////
    // state register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= wait_result;
        end else begin
            state <= state_nxt;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // bypass handshake
    //////////////////////////////////////////////////////////////////////

    // headers and trailers always take exactly one word, the counted
    // sections only take words while the counter has some left
    always_comb begin
        case (state)
            header_q, header_t, trailer_q, trailer_t, trailer_g: begin
                takes_word = 1'b1;
            end
            data_q, data_t, extra: begin
                takes_word = !section_empty;
            end
            default: begin
                takes_word = 1'b0;
            end
        endcase
    end

    // the output register must be able to take the rewritten word
    assign s2i_rdy = takes_word && out_free;
    assign xfer = s2i_rdy && s2i_valid;
    assign load = xfer;

    // only the header states hand a length to the counter
    assign len_is_target = (state == header_t);
    assign load_len = xfer && ((state == header_q) || (state == header_t));

    // counted sections step once per accepted word
    assign step = xfer && ((state == data_q) || (state == data_t) || (state == extra));

    // the result is released together with the last trailer word
    assign s1i_rdy = xfer && (state == trailer_g);

    //////////////////////////////////////////////////////////////////////
    // word select and next state
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        case (state)
            header_q:  sel = sel_q_header;
            trailer_q: sel = sel_trailer_q;
            trailer_t: sel = sel_trailer_t;
            trailer_g: sel = sel_trailer_g;
            default:   sel = sel_pass;
        endcase
    end

    always_comb begin
        state_nxt = state;
        load_extra = 1'b0;
        case (state)
            // nothing is forwarded before the result is there, since the
            // very first word already needs the local score
            wait_result: begin
                if (s1i_valid) begin
                    state_nxt = header_q;
                end
            end
            header_q: begin
                if (xfer) begin
                    state_nxt = data_q;
                end
            end
            // the counter is reloaded on the header edge, so section_empty
            // is already meaningful on the first cycle here
            data_q: begin
                if (section_empty) begin
                    state_nxt = header_t;
                end
            end
            header_t: begin
                if (xfer) begin
                    state_nxt = data_t;
                end
            end
            data_t: begin
                if (section_empty) begin
                    // the extra count is loaded on the way out
                    load_extra = 1'b1;
                    state_nxt = extra;
                end
            end
            extra: begin
                if (section_empty) begin
                    state_nxt = trailer_q;
                end
            end
            trailer_q: begin
                if (xfer) begin
                    state_nxt = trailer_t;
                end
            end
            trailer_t: begin
                if (xfer) begin
                    state_nxt = trailer_g;
                end
            end
            trailer_g: begin
                if (xfer) begin
                    state_nxt = wait_result;
                end
            end
            default: begin
                state_nxt = wait_result;
            end
        endcase
    end

    // the result fields are read all through the record, so the result
    // source must keep offering it until the last trailer takes it
    a_result_held: assert property (
        @(posedge clk) disable iff (rst)
        (state != wait_result) |-> s1i_valid
    );

endmodule

//--- source/merge_stream_top.sv
`timescale 1ns/1ps

// merges the bypass record stream with the alignment result stream
module merge_stream_top import merge_pkg::*; #(
    parameter int num_extra_tx = 3
) (
    input  logic         clk,
    input  logic         rst,

    // alignment results, one per record
    input  logic         s1i_valid,
    output logic         s1i_rdy,
    input  smwa_result_t s1i_data,

    // bypass record words
    input  logic         s2i_valid,
    output logic         s2i_rdy,
    input  stream_word_t s2i_data,

    // merged output stream
    output logic         s1o_valid,
    input  logic         s1o_rdy,
    output stream_word_t s1o_data
);

    // controller to builder
    logic      load;
    word_sel_t sel;
    logic      out_free;

    // controller to counter
    logic load_len;
    logic len_is_target;
    logic load_extra;
    logic step;
    logic section_empty;

    merge_ctrl i_ctrl (
        .clk           (clk),
        .rst           (rst),
        .s1i_valid     (s1i_valid),
        .s1i_rdy       (s1i_rdy),
        .s2i_valid     (s2i_valid),
        .s2i_rdy       (s2i_rdy),
        .out_free      (out_free),
        .section_empty (section_empty),
        .load          (load),
        .sel           (sel),
        .load_len      (load_len),
        .len_is_target (len_is_target),
        .load_extra    (load_extra),
        .step          (step)
    );

    tx_counter #(
        .num_extra_tx (num_extra_tx)
    ) i_tx_counter (
        .clk           (clk),
        .rst           (rst),
        .s2i_data      (s2i_data),
        .load_len      (load_len),
        .len_is_target (len_is_target),
        .load_extra    (load_extra),
        .step          (step),
        .section_empty (section_empty)
    );

    word_builder i_word_builder (
        .clk       (clk),
        .rst       (rst),
        .load      (load),
        .sel       (sel),
        .s1i_data  (s1i_data),
        .s2i_data  (s2i_data),
        .s1o_valid (s1o_valid),
        .s1o_rdy   (s1o_rdy),
        .s1o_data  (s1o_data),
        .out_free  (out_free)
    );

endmodule

//--- dv/merge_model.svh
// record generator, expected-word model and compare tasks, included
// into the testbench module body

localparam logic [31:0] seed = 32'h960bf2e3;
localparam int num_records = 40;

// bypass words in send order, with a flag on every third trailer word
stream_word_t byp_q[$];
bit           byp_last_q[$];
smwa_result_t res_q[$];

// expected output words, each with a label naming its record and section
stream_word_t exp_q[$];
string        tag_q[$];

logic [31:0] gen_state;

//////////////////////////////////////////////////////////////////////
// random source
//////////////////////////////////////////////////////////////////////

function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
endfunction

function automatic logic [31:0] gen_draw();
    gen_state = xorshift32(gen_state);
    return gen_state;
endfunction

function automatic stream_word_t rand_word();
    stream_word_t w;
    for (int i = 0; i < 4; i++) begin
        w[32*i +: 32] = gen_draw();
    end
    return w;
endfunction

// the corner lengths come round in turn, the rest are random
function automatic int pick_len(input int kind, input logic [31:0] rnd, input int span);
    case (kind % 6)
        0: return 0;
        1: return 64;
        2: return 1023;
        3: return 192;
        default: return int'(rnd % span);
    endcase
endfunction

//////////////////////////////////////////////////////////////////////
// record builder and model
//////////////////////////////////////////////////////////////////////

task automatic push_word(input stream_word_t sent, input stream_word_t expected,
                         input bit last, input string tag);
    byp_q.push_back(sent);
    byp_last_q.push_back(last);
    exp_q.push_back(expected);
    tag_q.push_back(tag);
endtask

// words of a section that pass through untouched
task automatic push_plain(input int n, input string tag);
    stream_word_t w;
    for (int i = 0; i < n; i++) begin
        w = rand_word();
        push_word(w, w, 1'b0, $sformatf("%s%0d", tag, i));
    end
endtask

task automatic build_records();
    query_header_t  qh;
    query_header_t  qh_exp;
    target_header_t th;
    smwa_result_t   res;
    stream_word_t   trl;
    stream_word_t   w_exp;
    int             q_len;
    int             t_len;
    string          rec;
    for (int r = 0; r < num_records; r++) begin
        rec = $sformatf("rec%0d", r);
        res = '0;
        res.q_base_local = q_pos_w'(gen_draw());
        res.t_base_local = t_pos_w'(gen_draw());
        res.local_score = score_w'(gen_draw());
        res.t_base_global = t_pos_w'(gen_draw());
        res.global_score = score_w'(gen_draw());
        res_q.push_back(res);
        q_len = pick_len(r, gen_draw(), 1024);
        t_len = pick_len(r + 2, gen_draw(), 2048);

        // the query header keeps only its length and gains the local score
        qh = query_header_t'(rand_word());
        qh.len = 16'(q_len);
        qh_exp = '0;
        qh_exp.len = qh.len;
        qh_exp.score = res.local_score;
        push_word(qh, qh_exp, 1'b0, {rec, "_q_header"});
        push_plain((q_len + bases_per_tx - 1) / bases_per_tx, {rec, "_q_data"});

        th = target_header_t'(rand_word());
        th.len = 16'(t_len);
        push_word(th, th, 1'b0, {rec, "_t_header"});
        push_plain((t_len + bases_per_tx - 1) / bases_per_tx, {rec, "_t_data"});
        push_plain(num_extra_tx, {rec, "_extra"});

        // first trailer, query end base over the lower bypass half
        trl = rand_word();
        w_exp = '0;
        w_exp[63:0] = trl[63:0];
        w_exp[64 +: q_pos_w] = res.q_base_local;
        push_word(trl, w_exp, 1'b0, {rec, "_trailer_q"});

        // second trailer is built from the two target end bases alone
        trl = rand_word();
        w_exp = '0;
        w_exp[0 +: t_pos_w] = res.t_base_local;
        w_exp[64 +: t_pos_w] = res.t_base_global;
        push_word(trl, w_exp, 1'b0, {rec, "_trailer_t"});

        trl = rand_word();
        w_exp = {trl[127:64], longint'($signed(res.global_score))};
        push_word(trl, w_exp, 1'b1, {rec, "_trailer_g"});
    end
endtask

//////////////////////////////////////////////////////////////////////
// compare tasks
//////////////////////////////////////////////////////////////////////

task automatic check_word(input string name, input stream_word_t exp, input stream_word_t act);
    if (act !== exp) begin
        report_failure($sformatf("ERROR %s expected %h actual %h", name, exp, act));
    end
endtask

task automatic check_result_count(input string name, input int exp, input int act);
    if (act != exp) begin
        report_failure($sformatf("ERROR %s expected %0d actual %0d", name, exp, act));
    end
endtask

task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
        report_failure($sformatf("ERROR %s expected %b actual %b", name, exp, act));
    end
endtask

//--- dv/tb_merge_stream.sv
`timescale 1ns/1ps

module tb_merge_stream import merge_pkg::*; #(
    parameter int num_extra_tx = 3
);

    // limits in clock cycles for each kind of wait
    localparam int word_timeout = 400;
    localparam int result_timeout = 4000;
    localparam int drain_timeout = 400;

    logic         clk;
    logic         rst;
    logic         s1i_valid;
    logic         s1i_rdy;
    smwa_result_t s1i_data;
    logic         s2i_valid;
    logic         s2i_rdy;
    stream_word_t s2i_data;
    logic         s1o_valid;
    logic         s1o_rdy;
    stream_word_t s1o_data;

    // every driver has its own random stream so the draws do not interleave
    logic [31:0] byp_state;
    logic [31:0] res_state;
    logic [31:0] sink_state;

    // bypass words seen so far, records finished and result release pulses
    int byp_idx;
    int records_done;
    int consumed;

    `include "merge_model.svh"

    merge_stream_top #(
        .num_extra_tx (num_extra_tx)
    ) i_dut (
        .clk       (clk),
        .rst       (rst),
        .s1i_valid (s1i_valid),
        .s1i_rdy   (s1i_rdy),
        .s1i_data  (s1i_data),
        .s2i_valid (s2i_valid),
        .s2i_rdy   (s2i_rdy),
        .s2i_data  (s2i_data),
        .s1o_valid (s1o_valid),
        .s1o_rdy   (s1o_rdy),
        .s1o_data  (s1o_data)
    );

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // drivers
    //////////////////////////////////////////////////////////////////////

    // the sink takes a word on most cycles and backs off now and then
    initial begin
        forever begin
            @(posedge clk);
            #1;
            sink_state = xorshift32(sink_state);
            s1o_rdy = (sink_state[2:0] != 3'd0);
        end
    end

    // each bypass word may follow a short gap, then stays offered until taken
    task automatic drive_bypass();
        int gap;
        int waited;
        for (int i = 0; i < byp_q.size(); i++) begin
            byp_state = xorshift32(byp_state);
            gap = (byp_state[3:0] < 4'd5) ? int'(byp_state[6:4]) : 0;
            s2i_valid = 1'b0;
            repeat (gap) begin
                @(posedge clk);
                #1;
            end
            s2i_valid = 1'b1;
            s2i_data = byp_q[i];
            waited = 0;
            @(negedge clk);
            while (!s2i_rdy) begin
                waited++;
                if (waited > word_timeout) begin
                    report_failure($sformatf("bypass word %0d was never accepted", i));
                end
                @(negedge clk);
            end
            @(posedge clk);
            #1;
        end
        s2i_valid = 1'b0;
    endtask

    // a result is offered after a random delay and held until released
    task automatic drive_results();
        int gap;
        int waited;
        for (int r = 0; r < num_records; r++) begin
            res_state = xorshift32(res_state);
            gap = int'(res_state[2:0]);
            s1i_valid = 1'b0;
            repeat (gap) begin
                @(posedge clk);
                #1;
            end
            s1i_valid = 1'b1;
            s1i_data = res_q[r];
            waited = 0;
            @(negedge clk);
            while (!s1i_rdy) begin
                waited++;
                if (waited > result_timeout) begin
                    report_failure($sformatf("result of record %0d was never consumed", r));
                end
                @(negedge clk);
            end
            @(posedge clk);
            #1;
        end
        s1i_valid = 1'b0;
    endtask

    //////////////////////////////////////////////////////////////////////
    // monitor
    //////////////////////////////////////////////////////////////////////

    // inputs settle 1 ns after the rising edge, so the falling edge shows
    // exactly what the next rising edge will transfer
    always @(negedge clk) begin
        if (!rst) begin
            if (s1o_valid && s1o_rdy) begin
                if (exp_q.size() == 0) begin
                    report_failure("an output word appeared after all expected words");
                end else begin
                    check_word(tag_q.pop_front(), exp_q.pop_front(), s1o_data);
                end
            end
            if (s2i_valid && s2i_rdy) begin
                if (byp_last_q[byp_idx]) begin
                    records_done++;
                end
                byp_idx++;
            end
            // every release pulse counts, even one with no result offered
            if (s1i_rdy) begin
                consumed++;
            end
            // the result must leave on the very edge of the third trailer word
            check_result_count("result_release", records_done, consumed);
        end
    end

    //////////////////////////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        int waited;
        rst = 1'b1;
        s1i_valid = 1'b0;
        s1i_data = '0;
        s2i_valid = 1'b0;
        s2i_data = '0;
        s1o_rdy = 1'b0;
        gen_state = seed;
        byp_state = xorshift32(seed ^ 32'h0000_00b1);
        res_state = xorshift32(seed ^ 32'h0000_2c07);
        sink_state = xorshift32(seed ^ 32'h0005_e11d);
        byp_idx = 0;
        records_done = 0;
        consumed = 0;
        build_records();

        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;

        // nothing is offered yet, so every handshake output stays low
        repeat (4) begin
            @(negedge clk);
            check_flag("idle_s1o_valid", 1'b0, s1o_valid);
            check_flag("idle_s1i_rdy", 1'b0, s1i_rdy);
            check_flag("idle_s2i_rdy", 1'b0, s2i_rdy);
        end

        @(posedge clk);
        #1;
        fork
            drive_bypass();
            drive_results();
        join

        waited = 0;
        while (exp_q.size() != 0) begin
            waited++;
            if (waited > drain_timeout) begin
                report_failure("output stream stopped with words still expected");
            end
            @(negedge clk);
        end

        // quiet cycles let the monitor catch any extra word or release pulse
        repeat (10) @(negedge clk);
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

//--- all.f
+incdir+dv
source/merge_pkg.sv
source/tx_counter.sv
source/word_builder.sv
source/merge_ctrl.sv
source/merge_stream_top.sv
dv/tb_merge_stream.sv

//--- run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it once and judge by its printout
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f all.f \
    --top-module tb_merge_stream -o sim_merge_stream || exit 1
out=$(./obj_dir/sim_merge_stream 2>&1)
echo "$out"
echo "$out" | grep -q "^TEST RESULT: PASS$" && echo "run passed" || { echo "run failed"; exit 1; }
